// File: hdl/tag_defines.svh
//--------------------------------------------------
// Sizing macros for the tag bring-up path
// Include in any file that sizes tag packets,
// trace ROM words or the reset release chain
//--------------------------------------------------
`ifndef TAG_DEFINES_SVH
`define TAG_DEFINES_SVH

//--------------------------------------------------
// Tag network
//--------------------------------------------------
`define TAG_NUM_CLIENTS 4
`define TAG_ID_W        2
`define TAG_PAYLOAD_W   8

// Start bit plus id plus payload
`define TAG_PKT_BITS    (1 + `TAG_ID_W + `TAG_PAYLOAD_W)

//--------------------------------------------------
// Trace ROM and reset release
//--------------------------------------------------
`define TRACE_ADDR_W    6

// Flop stages between tag done and core reset release
`define RESET_DEPTH     3

`endif

// File: hdl/tag_trace_pkg.sv
//--------------------------------------------------
// Trace ROM entry format for the tag replayer
// The struct layout is the ROM word layout, so a
// ROM model can build entries from these types
//--------------------------------------------------
`include "tag_defines.svh"

package tag_trace_pkg;

  // Trace opcodes
  typedef enum logic [1:0] {
    e_op_nop  = 2'b00,
    e_op_send = 2'b01,
    e_op_wait = 2'b10,
    e_op_done = 2'b11
  } trace_op_e;

  // One ROM word, opcode in the top bits
  // Wait entries reuse payload as the idle cycle count
  typedef struct packed {
    trace_op_e                 op;
    logic [`TAG_ID_W-1:0]      id;
    logic [`TAG_PAYLOAD_W-1:0] payload;
  } trace_entry_t;

endpackage

// File: hdl/tag_link_pkg.sv
//--------------------------------------------------
// Types for the serial tag link and its receiver
// Shared by the tag master and the top level
//--------------------------------------------------
`include "tag_defines.svh"

package tag_link_pkg;

  // Packet fields
  typedef logic [`TAG_ID_W-1:0]      tag_client_id_t;
  typedef logic [`TAG_PAYLOAD_W-1:0] tag_payload_t;

  // Receiver FSM
  typedef enum logic [1:0] {
    e_rx_idle    = 2'b00,
    e_rx_id      = 2'b01,
    e_rx_payload = 2'b10
  } tag_rx_state_e;

endpackage

// File: hdl/tag_trace_replay.sv
//--------------------------------------------------
// Trace replayer for tag bring-up
// Fetches entries from a combinational trace ROM
// and turns send entries into serial tag packets,
// LSB first after a start bit. Wait entries idle
// the line, a done entry stops the walk for good
//--------------------------------------------------
`include "tag_defines.svh"

module tag_trace_replay
  import tag_trace_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  output logic [`TRACE_ADDR_W-1:0] rom_addr_o,
  input  trace_entry_t             rom_data_i,

  output logic                     tag_valid_o,
  output logic                     tag_data_o,
  output logic                     tag_done_o
);

  // FSM state is the opcode being executed
  // Nop means fetching
  trace_op_e                 state_r;
  logic [`TRACE_ADDR_W-1:0]  addr_r;
  logic [`TAG_PAYLOAD_W-1:0] cnt_r;
  logic [`TAG_PKT_BITS-1:0]  shift_r;
  logic                      last_w;
  logic                      load_pkt_w;

  assign last_w     = (cnt_r == `TAG_PAYLOAD_W'(1));
  assign load_pkt_w = (state_r == e_op_nop) && (rom_data_i.op == e_op_send);

  //--------------------------------------------------
  // Entry sequencing
  //--------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= e_op_nop;
      addr_r  <= '0;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        e_op_nop: begin
          case (rom_data_i.op)
            e_op_send: begin
              state_r <= e_op_send;
              cnt_r   <= `TAG_PAYLOAD_W'(`TAG_PKT_BITS);
            end
            e_op_wait: begin
              // Zero-length wait finishes in its fetch cycle
              if (rom_data_i.payload == '0) begin
                addr_r <= addr_r + 1'b1;
              end else begin
                state_r <= e_op_wait;
                cnt_r   <= rom_data_i.payload;
              end
            end
            e_op_done: begin
              state_r <= e_op_done;
            end
            default: begin
              addr_r <= addr_r + 1'b1;
            end
          endcase
        end
        e_op_send, e_op_wait: begin
          cnt_r <= cnt_r - 1'b1;
          if (last_w) begin
            state_r <= e_op_nop;
            addr_r  <= addr_r + 1'b1;
          end
        end
        default: begin
          // Terminal, address stays put
          state_r <= e_op_done;
        end
      endcase
    end
  end

  // Packet shifter, start bit goes out first
  always_ff @(posedge clk_i) begin
    if (load_pkt_w) begin
      shift_r <= {rom_data_i.payload, rom_data_i.id, 1'b1};
    end else if (state_r == e_op_send) begin
      shift_r <= {1'b0, shift_r[`TAG_PKT_BITS-1:1]};
    end
  end

  assign rom_addr_o  = addr_r;
  assign tag_valid_o = (state_r == e_op_send);
  assign tag_data_o  = tag_valid_o & shift_r[0];
  assign tag_done_o  = (state_r == e_op_done);

  //--------------------------------------------------
  // Checks
  //--------------------------------------------------
  // Line stays quiet once done and done never drops
  a_quiet_after_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tag_done_o |-> !tag_valid_o ##1 tag_done_o);

  // No address movement mid-packet
  a_addr_stable_send: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tag_valid_o |-> $stable(rom_addr_o));

endmodule

// File: hdl/tag_master.sv
//--------------------------------------------------
// Tag master
// Deserializes packets from the one-bit tag line
// and writes the addressed client configuration
// register. Each client also gets a sticky flag
// set on its first write
//--------------------------------------------------
`include "tag_defines.svh"

module tag_master
  import tag_link_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  input  logic                                tag_valid_i,
  input  logic                                tag_data_i,

  output tag_payload_t [`TAG_NUM_CLIENTS-1:0] client_data_o,
  output logic         [`TAG_NUM_CLIENTS-1:0] client_written_o
);

  localparam int CNT_W = $clog2(`TAG_PKT_BITS);

  tag_rx_state_e  state_r;
  logic [CNT_W-1:0] cnt_r;
  tag_client_id_t id_r;
  tag_payload_t   payload_r;
  tag_payload_t   payload_next;
  logic           bit_w;
  logic           id_last_w;
  logic           pl_last_w;

  // Line reads as zero whenever valid is low
  assign bit_w        = tag_valid_i & tag_data_i;
  assign payload_next = {bit_w, payload_r[`TAG_PAYLOAD_W-1:1]};
  assign id_last_w    = (cnt_r == CNT_W'(`TAG_ID_W - 1));
  assign pl_last_w    = (cnt_r == CNT_W'(`TAG_PAYLOAD_W - 1));

  //--------------------------------------------------
  // Receive FSM and client registers
  //--------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r          <= e_rx_idle;
      cnt_r            <= '0;
      client_data_o    <= '0;
      client_written_o <= '0;
    end else begin
      case (state_r)
        e_rx_idle: begin
          // Wait for start bit
          if (bit_w) begin
            state_r <= e_rx_id;
            cnt_r   <= '0;
          end
        end
        e_rx_id: begin
          if (id_last_w) begin
            state_r <= e_rx_payload;
            cnt_r   <= '0;
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        e_rx_payload: begin
          if (pl_last_w) begin
            state_r                <= e_rx_idle;
            client_data_o[id_r]    <= payload_next;
            client_written_o[id_r] <= 1'b1;
          end else begin
            cnt_r <= cnt_r + 1'b1;
          end
        end
        default: begin
          state_r <= e_rx_idle;
        end
      endcase
    end
  end

  // Field shifters, LSB arrives first
  always_ff @(posedge clk_i) begin
    if (state_r == e_rx_id) begin
      id_r <= {bit_w, id_r[`TAG_ID_W-1:1]};
    end
    if (state_r == e_rx_payload) begin
      payload_r <= payload_next;
    end
  end

  // Sender must keep valid up for the whole packet
  a_valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_r != e_rx_idle) |-> tag_valid_i);

endmodule

// File: hdl/reset_release.sv
//--------------------------------------------------
// Core reset release
// Keeps the core in reset until tag programming is
// done, then lets it go through a short flop chain
//--------------------------------------------------
`include "tag_defines.svh"

module reset_release (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic tag_done_i,
  output logic core_rst_n_o
);

  logic [`RESET_DEPTH-1:0] chain_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      chain_r <= '0;
    end else begin
      chain_r[0] <= tag_done_i;
      for (int i = 1; i < `RESET_DEPTH; i++) begin
        chain_r[i] <= chain_r[i-1];
      end
    end
  end

  // Last stage is the active-low core reset
  assign core_rst_n_o = chain_r[`RESET_DEPTH-1];

  //--------------------------------------------------
  // Checks
  //--------------------------------------------------
  // Once released, only the harness reset pulls it back
  a_release_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_rst_n_o |=> core_rst_n_o);

endmodule

// File: hdl/tag_boot_top.sv
//--------------------------------------------------
// Tag bring-up top level
// Trace replayer drives the tag line into the tag
// master, and the done level releases core reset.
// The trace ROM sits outside on plain ports
//--------------------------------------------------
`include "tag_defines.svh"

module tag_boot_top
  import tag_trace_pkg::*;
  import tag_link_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  // Trace ROM, combinational read
  output logic         [`TRACE_ADDR_W-1:0]    rom_addr_o,
  input  trace_entry_t                        rom_data_i,

  // Client configuration state
  output tag_payload_t [`TAG_NUM_CLIENTS-1:0] client_data_o,
  output logic         [`TAG_NUM_CLIENTS-1:0] client_written_o,

  output logic                                tag_done_o,
  output logic                                core_rst_n_o
);

  logic tag_valid;
  logic tag_data;
  logic tag_done;

  tag_trace_replay replay0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rom_addr_o  (rom_addr_o),
    .rom_data_i  (rom_data_i),
    .tag_valid_o (tag_valid),
    .tag_data_o  (tag_data),
    .tag_done_o  (tag_done)
  );

  tag_master master0 (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .tag_valid_i      (tag_valid),
    .tag_data_i       (tag_data),
    .client_data_o    (client_data_o),
    .client_written_o (client_written_o)
  );

  // Hold core reset until programming is done
  reset_release release0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tag_done_i   (tag_done),
    .core_rst_n_o (core_rst_n_o)
  );

  assign tag_done_o = tag_done;

endmodule

// File: testbench/tag_boot_tb.sv
//--------------------------------------------------
// Testbench for the tag bring-up top level
// Holds a trace image in a combinational ROM model,
// walks it with a cycle-level reference model and
// checks the DUT against it with concurrent
// assertions. Only reset is driven
//--------------------------------------------------
`include "tag_defines.svh"

module tag_boot_tb
  import tag_trace_pkg::*;
  import tag_link_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ROM_DEPTH = 1 << `TRACE_ADDR_W;

  logic                                clk;
  logic                                rst_n;
  logic         [`TRACE_ADDR_W-1:0]    rom_addr;
  trace_entry_t                        rom_data;
  tag_payload_t [`TAG_NUM_CLIENTS-1:0] client_data;
  logic         [`TAG_NUM_CLIENTS-1:0] client_written;
  logic                                tag_done;
  logic                                core_rst_n;

  trace_entry_t image [ROM_DEPTH];

  // Reference model state
  logic         [`TRACE_ADDR_W-1:0]    exp_addr;
  int                                  exp_cyc;
  logic                                exp_done;
  int                                  done_cyc;
  logic                                exp_core_rst_n;
  tag_payload_t [`TAG_NUM_CLIENTS-1:0] exp_data;
  logic         [`TAG_NUM_CLIENTS-1:0] exp_written;
  int                                  entries;

  int value_errs;
  int other_errs;
  int cycles;
  int limit;

  tag_boot_top dut0 (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .rom_addr_o       (rom_addr),
    .rom_data_i       (rom_data),
    .client_data_o    (client_data),
    .client_written_o (client_written),
    .tag_done_o       (tag_done),
    .core_rst_n_o     (core_rst_n)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  assign rom_data = image[rom_addr];

  function automatic trace_entry_t make_entry(trace_op_e op, int id, int payload);
    trace_entry_t e;
    e.op      = op;
    e.id      = `TAG_ID_W'(id);
    e.payload = `TAG_PAYLOAD_W'(payload);
    return e;
  endfunction

  // Cycles an entry occupies including its fetch cycle
  function automatic int entry_len(trace_entry_t e);
    case (e.op)
      e_op_send: return `TAG_PKT_BITS + 1;
      e_op_wait: return int'(e.payload) + 1;
      default:   return 1;
    endcase
  endfunction

  //--------------------------------------------------
  // Reference model
  //--------------------------------------------------
  always @(posedge clk) begin : model_step
    trace_entry_t cur;
    cur = image[exp_addr];
    if (!rst_n) begin
      exp_addr    <= '0;
      exp_cyc     <= 0;
      exp_done    <= 1'b0;
      done_cyc    <= 0;
      exp_data    <= '0;
      exp_written <= '0;
      entries     <= 0;
    end else if (exp_done) begin
      if (done_cyc < `RESET_DEPTH) begin
        done_cyc <= done_cyc + 1;
      end
    end else if (exp_cyc + 1 == entry_len(cur)) begin
      exp_cyc <= 0;
      entries <= entries + 1;
      case (cur.op)
        e_op_send: begin
          exp_data[cur.id]    <= cur.payload;
          exp_written[cur.id] <= 1'b1;
          exp_addr            <= exp_addr + 1'b1;
        end
        e_op_done: exp_done <= 1'b1;
        default:   exp_addr <= exp_addr + 1'b1;
      endcase
    end else begin
      exp_cyc <= exp_cyc + 1;
    end
  end

  assign exp_core_rst_n = (done_cyc >= `RESET_DEPTH);

  //--------------------------------------------------
  // Checks
  //--------------------------------------------------
  a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
    (!tag_done && client_written == '0 && !core_rst_n && !dut0.tag_valid))
    else begin
      value_errs++;
      $write("Error: time %0t after reset tag_done_o=%b client_written_o=%b",
        $time, $sampled(tag_done), $sampled(client_written));
      $display(" core_rst_n_o=%b tag_valid=%b, expected all low",
        $sampled(core_rst_n), $sampled(dut0.tag_valid));
    end

  a_client_data: assert property (@(posedge clk) disable iff (!rst_n)
    client_data == exp_data)
    else begin
      value_errs++;
      $display("Error: time %0t client_data_o got %h expected %h",
        $time, $sampled(client_data), $sampled(exp_data));
    end

  a_client_written: assert property (@(posedge clk) disable iff (!rst_n)
    client_written == exp_written)
    else begin
      value_errs++;
      $display("Error: time %0t client_written_o got %b expected %b",
        $time, $sampled(client_written), $sampled(exp_written));
    end

  // Address tracks the entry timing cycle by cycle
  a_rom_addr: assert property (@(posedge clk) disable iff (!rst_n)
    rom_addr == exp_addr)
    else begin
      value_errs++;
      $display("Error: time %0t rom_addr_o got %0d expected %0d",
        $time, $sampled(rom_addr), $sampled(exp_addr));
    end

  a_tag_done: assert property (@(posedge clk) disable iff (!rst_n)
    tag_done == exp_done)
    else begin
      value_errs++;
      $display("Error: time %0t tag_done_o got %b expected %b",
        $time, $sampled(tag_done), $sampled(exp_done));
    end

  a_core_rst: assert property (@(posedge clk) disable iff (!rst_n)
    core_rst_n == exp_core_rst_n)
    else begin
      value_errs++;
      $display("Error: time %0t core_rst_n_o got %b expected %b",
        $time, $sampled(core_rst_n), $sampled(exp_core_rst_n));
    end

  a_core_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    core_rst_n |=> core_rst_n)
    else begin
      other_errs++;
      $display("Core reset dropped again after release at %0t", $time);
    end

  a_frozen_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    tag_done |=> ($stable(rom_addr) && $stable(client_data)))
    else begin
      other_errs++;
      $display("ROM address or client data moved after done at %0t", $time);
    end

  //--------------------------------------------------
  // Cycle limit
  //--------------------------------------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Run hit the cycle limit of %0d before core reset was released", limit);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    int a;
    rst_n      = 1'b0;
    value_errs = 0;
    other_errs = 0;
    cycles     = 0;
    limit      = 0;
    void'($urandom(32'h2b31));

    // Unused words decode as done, tagged with their address
    for (a = 0; a < ROM_DEPTH; a++) begin
      image[a] = make_entry(e_op_done, a, a);
    end
    image[0] = make_entry(e_op_send, 0, int'($urandom() & 8'hff));
    image[1] = make_entry(e_op_send, 1, int'($urandom() & 8'hff));
    image[2] = make_entry(e_op_nop, 0, 0);
    image[3] = make_entry(e_op_send, 2, int'($urandom() & 8'hff));
    image[4] = make_entry(e_op_wait, 0, 7);
    image[5] = make_entry(e_op_send, 3, int'($urandom() & 8'hff));
    image[6] = make_entry(e_op_send, 2, int'($urandom() & 8'hff));
    image[7] = make_entry(e_op_done, 0, 0);

    a = 0;
    while (image[a].op != e_op_done) begin
      limit = limit + entry_len(image[a]);
      a++;
    end
    limit = 2 * (limit + entry_len(image[a])) + 50;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    while (core_rst_n !== 1'b1) begin
      @(posedge clk);
    end
    // Some quiet cycles for the frozen and sticky checks
    repeat (12) @(posedge clk);

    $display("Replayed %0d entries with %0d value errors and %0d other errors",
      entries, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+hdl
hdl/tag_trace_pkg.sv
hdl/tag_link_pkg.sv
hdl/tag_trace_replay.sv
hdl/tag_master.sv
hdl/reset_release.sv
hdl/tag_boot_top.sv
testbench/tag_boot_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the tag bring-up testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tag_boot_tb \
  -f src.f -o tag_boot_sim > build.log 2>&1 \
  && ./obj_dir/tag_boot_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "FAIL: build or run error"; exit 1; }

cat sim.log
grep -qx "All checks passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
